// ==== source/fetch_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end sizing and memory map
// predictor geometry and the physical address windows used by fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// predictor geometry
// number of banks, selected by pc[3:2]
`define BP_BANKS 4

// entries in each bank, selected by pc[6:4]
`define BP_ENTRIES 8

// tag bits kept per entry, taken from pc just above the index
`define BP_TAG_W 8

// physical memory map, only checked with translation off
// unmapped hole between lower (inclusive) and upper (exclusive)
`define UNMAPPED_LOWER 64'h0000_0000_0010_0000

`define UNMAPPED_UPPER 64'h0000_0000_4000_0000

// everything at or above this address is outside memory
`define PHYS_MEM_LIMIT 64'h0000_0080_0000_0000

`endif

// ==== source/riscv_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// riscv architectural types
// address widths and the synchronous exception cause codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package riscv_pkg;

    // register width of the core
    localparam int XLEN = 64;

    // virtual address bits sent to the instruction cache
    localparam int VADDR_W = 40;

    typedef logic [VADDR_W-1:0] addr_t;

    typedef logic [XLEN-1:0] pc_t;

    // mcause codes for synchronous exceptions
    // fetch only raises the first two
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED  = 4'd0,
        INSTR_ACCESS_FAULT     = 4'd1,
        ILLEGAL_INSTR          = 4'd2,
        BREAKPOINT             = 4'd3,
        LD_ADDR_MISALIGNED     = 4'd4,
        LD_ACCESS_FAULT        = 4'd5,
        ST_AMO_ADDR_MISALIGNED = 4'd6,
        ST_AMO_ACCESS_FAULT    = 4'd7,
        USER_ECALL             = 4'd8,
        SUPERVISOR_ECALL       = 4'd9,
        RESERVED_10            = 4'd10,
        MACHINE_ECALL          = 4'd11,
        INSTR_PAGE_FAULT       = 4'd12,
        LD_PAGE_FAULT          = 4'd13,
        RESERVED_14            = 4'd14,
        ST_AMO_PAGE_FAULT      = 4'd15
    } exc_cause_t;

endpackage

`default_nettype wire

// ==== source/fetch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch pipeline types
// next-pc select, predictor entry layout and the fetch pc views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    import riscv_pkg::*;

    // field widths derived from the predictor geometry
    localparam int BP_BANK_W = $clog2(`BP_BANKS);
    localparam int BP_IDX_W = $clog2(`BP_ENTRIES);
    localparam int BP_UPPER_W = XLEN - `BP_TAG_W - BP_IDX_W - BP_BANK_W - 2;

    typedef logic [BP_BANK_W-1:0] bp_bank_t;
    typedef logic [BP_IDX_W-1:0] bp_idx_t;
    typedef logic [`BP_TAG_W-1:0] bp_tag_t;

    // next pc source, driven by the control unit
    typedef enum logic [1:0] {
        KEEP_PC    = 2'b00,
        BP_OR_PC_4 = 2'b01,
        JUMP       = 2'b10,
        DEBUG      = 2'b11
    } next_pc_sel_t;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } bp_decision_t;

    // one predictor slot, counter msb gives the direction
    typedef struct packed {
        logic       valid;
        bp_tag_t    tag;
        pc_t        target;
        logic [1:0] counter;
    } bp_entry_t;

    // predictor view of a pc, msb first
    typedef struct packed {
        logic [BP_UPPER_W-1:0] upper;
        bp_tag_t               tag;
        bp_idx_t               index;
        bp_bank_t              bank;
        logic [1:0]            offset;
    } fetch_pc_fields_t;

    // same 64 bits, raw for arithmetic or split for the predictor
    typedef union packed {
        pc_t              raw;
        fetch_pc_fields_t fields;
    } fetch_pc_u;

endpackage

`default_nettype wire

// ==== source/bp_update_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor update router
// turns a resolved branch into a one-hot bank write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

module bp_update_router
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 exe_valid_i,
    input  pc_t                  exe_pc_i,
    input  pc_t                  exe_target_i,
    input  logic                 exe_taken_i,
    output logic [`BP_BANKS-1:0] wr_en_o,
    output bp_idx_t              wr_index_o,
    output bp_tag_t              wr_tag_o,
    output pc_t                  wr_target_o,
    output logic                 wr_taken_o
);

    fetch_pc_u exe_pc;

    assign exe_pc.raw = exe_pc_i;

    // bank select from pc[3:2], only on a valid update
    always_comb begin
        wr_en_o = '0;
        if (exe_valid_i) begin
            wr_en_o[exe_pc.fields.bank] = 1'b1;
        end
    end

    assign wr_index_o  = exe_pc.fields.index;
    assign wr_tag_o    = exe_pc.fields.tag;
    assign wr_target_o = exe_target_i;
    assign wr_taken_o  = exe_taken_i;

    // exactly one bank written per valid update, none otherwise
    a_wr_en_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(wr_en_o) && ((|wr_en_o) == exe_valid_i));

endmodule

`default_nettype wire

// ==== source/bp_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor bank
// tagged target entries with 2-bit saturating direction counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

module bp_bank
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        wr_en_i,
    input  bp_idx_t                     wr_index_i,
    input  bp_tag_t                     wr_tag_i,
    input  pc_t                         wr_target_i,
    input  logic                        wr_taken_i,
    output bp_entry_t [`BP_ENTRIES-1:0] entries_o
);

    bp_entry_t [`BP_ENTRIES-1:0] entries_q;
    bp_entry_t                   stored;
    bp_entry_t                   new_entry;
    logic                        hit;

    // compute the entry written at wr_index_i
    always_comb begin
        stored = entries_q[wr_index_i];
        hit    = stored.valid && (stored.tag == wr_tag_i);

        new_entry.valid  = 1'b1;
        new_entry.tag    = wr_tag_i;
        new_entry.target = wr_target_i;

        if (hit) begin
            // a repeat of the same branch trains the counter
            if (wr_taken_i) begin
                new_entry.counter = (stored.counter == 2'b11) ? 2'b11 : stored.counter + 2'd1;
            end else begin
                new_entry.counter = (stored.counter == 2'b00) ? 2'b00 : stored.counter - 2'd1;
            end
        end else begin
            // new allocation starts weakly biased
            new_entry.counter = wr_taken_i ? 2'b10 : 2'b01;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                entries_q[i] <= '{valid: 1'b0, tag: '0, target: '0, counter: 2'b01};
            end
        end else if (wr_en_i) begin
            entries_q[wr_index_i] <= new_entry;
        end
    end

    assign entries_o = entries_q;

endmodule

`default_nettype wire

// ==== source/bp_lookup_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch predictor lookup
// picks the entry addressed by the fetch pc and forms the prediction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

module bp_lookup_select
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  pc_t                                    pc_i,
    input  bp_entry_t [`BP_BANKS*`BP_ENTRIES-1:0] bank_entries_i,
    output logic                                   is_branch_o,
    output logic                                   taken_o,
    output pc_t                                    target_o
);

    fetch_pc_u                       pc;
    logic [BP_BANK_W+BP_IDX_W-1:0] sel;
    bp_entry_t                       entry;

    assign pc.raw = pc_i;

    // banks are laid out bank-major, so bank and index concatenate
    assign sel   = {pc.fields.bank, pc.fields.index};
    assign entry = bank_entries_i[sel];

    // hit needs a live slot with the same tag
    assign is_branch_o = entry.valid && (entry.tag == pc.fields.tag);

    // direction is the counter msb
    assign taken_o  = entry.counter[1];
    assign target_o = entry.target;

endmodule

`default_nettype wire

// ==== source/fetch_pc_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first fetch stage pc logic
// pc register, next-pc choice, fetch fault checks, cache request
// and the packet handed to the second fetch stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_stage
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  addr_t        reset_addr_i,
    input  next_pc_sel_t next_pc_sel_i,
    input  pc_t          pc_jump_i,
    input  logic         stall_i,
    input  logic         stall_debug_i,
    input  logic         en_translation_i,
    input  logic         invalidate_icache_i,
    input  logic         invalidate_buffer_i,
    input  logic         retry_fetch_i,
    input  logic         bp_is_branch_i,
    input  logic         bp_taken_i,
    input  pc_t          bp_target_i,
    output pc_t          pc_o,
    output logic         req_valid_o,
    output addr_t        req_vaddr_o,
    output logic         req_inval_icache_o,
    output logic         req_inval_buffer_o,
    output logic         req_inval_fetch_o,
    output logic         fetch_valid_o,
    output pc_t          fetch_pc_o,
    output logic         fetch_ex_valid_o,
    output exc_cause_t   fetch_ex_cause_o,
    output pc_t          fetch_ex_origin_o,
    output logic         fetch_bp_is_branch_o,
    output bp_decision_t fetch_bp_decision_o,
    output pc_t          fetch_bp_addr_o
);

    fetch_pc_u pc_q;
    pc_t       next_pc;
    logic      pred_taken;
    logic      ex_misaligned;
    logic      ex_fault;
    logic      not_stalled;

    assign pred_taken = bp_is_branch_i && bp_taken_i;

    always_comb begin
        case (next_pc_sel_i)
            KEEP_PC:    next_pc = pc_q.raw;
            BP_OR_PC_4: next_pc = pred_taken ? bp_target_i : pc_q.raw + 64'd4;
            JUMP,
            DEBUG:      next_pc = pc_jump_i;
            default:    next_pc = pc_q.raw + 64'd4;
        endcase
    end

    // stalls do not hold the pc, the control unit selects KEEP_PC instead
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q.raw <= pc_t'(reset_addr_i);
        end else begin
            pc_q.raw <= next_pc;
        end
    end

    assign ex_misaligned = |pc_q.fields.offset;

    // sv39 canonical form with translation, memory map without
    always_comb begin
        if (en_translation_i) begin
            ex_fault = pc_q.raw[63:39] != {25{pc_q.raw[38]}};
        end else begin
            ex_fault = ((pc_q.raw >= `UNMAPPED_LOWER) && (pc_q.raw < `UNMAPPED_UPPER))
                       || (pc_q.raw >= `PHYS_MEM_LIMIT);
        end
    end

    // misalignment reported ahead of the access fault
    always_comb begin
        fetch_ex_valid_o = ex_misaligned || ex_fault;
        if (ex_misaligned) begin
            fetch_ex_cause_o = INSTR_ADDR_MISALIGNED;
        end else if (ex_fault) begin
            fetch_ex_cause_o = INSTR_ACCESS_FAULT;
        end else begin
            fetch_ex_cause_o = INSTR_ADDR_MISALIGNED;
        end
    end

    assign not_stalled = !stall_i && !stall_debug_i;

    // cache request, suppressed on any fetch exception
    assign req_valid_o        = not_stalled && !fetch_ex_valid_o;
    assign req_vaddr_o        = pc_q.raw[$bits(addr_t)-1:0];
    assign req_inval_icache_o = invalidate_icache_i;
    assign req_inval_buffer_o = invalidate_buffer_i || retry_fetch_i;
    assign req_inval_fetch_o  = retry_fetch_i;

    // packet to the second stage
    assign pc_o                 = pc_q.raw;
    assign fetch_valid_o        = not_stalled;
    assign fetch_pc_o           = pc_q.raw;
    assign fetch_ex_origin_o    = pc_q.raw;
    assign fetch_bp_is_branch_o = bp_is_branch_i;
    assign fetch_bp_decision_o  = pred_taken ? PRED_TAKEN : PRED_NOT_TAKEN;
    assign fetch_bp_addr_o      = bp_target_i;

    a_sel_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(next_pc_sel_i));

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end top
// pc stage with a banked branch predictor behind it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend
    import riscv_pkg::*;
    import fetch_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  addr_t        reset_addr_i,
    input  logic         stall_i,
    input  logic         stall_debug_i,
    input  next_pc_sel_t next_pc_sel_i,
    input  pc_t          pc_jump_i,
    input  logic         invalidate_icache_i,
    input  logic         invalidate_buffer_i,
    input  logic         retry_fetch_i,
    input  logic         en_translation_i,
    input  logic         exe_valid_i,
    input  pc_t          exe_pc_i,
    input  pc_t          exe_target_i,
    input  logic         exe_taken_i,
    output logic         req_valid_o,
    output addr_t        req_vaddr_o,
    output logic         req_inval_icache_o,
    output logic         req_inval_buffer_o,
    output logic         req_inval_fetch_o,
    output logic         fetch_valid_o,
    output pc_t          fetch_pc_o,
    output logic         fetch_ex_valid_o,
    output exc_cause_t   fetch_ex_cause_o,
    output pc_t          fetch_ex_origin_o,
    output logic         fetch_bp_is_branch_o,
    output bp_decision_t fetch_bp_decision_o,
    output pc_t          fetch_bp_addr_o
);

    pc_t                                    pc;
    logic [`BP_BANKS-1:0]                   wr_en;
    bp_idx_t                                wr_index;
    bp_tag_t                                wr_tag;
    pc_t                                    wr_target;
    logic                                   wr_taken;
    bp_entry_t [`BP_BANKS*`BP_ENTRIES-1:0] bank_entries;
    logic                                   bp_is_branch;
    logic                                   bp_taken;
    pc_t                                    bp_target;

    fetch_pc_stage i_pc_stage (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .reset_addr_i         (reset_addr_i),
        .next_pc_sel_i        (next_pc_sel_i),
        .pc_jump_i            (pc_jump_i),
        .stall_i              (stall_i),
        .stall_debug_i        (stall_debug_i),
        .en_translation_i     (en_translation_i),
        .invalidate_icache_i  (invalidate_icache_i),
        .invalidate_buffer_i  (invalidate_buffer_i),
        .retry_fetch_i        (retry_fetch_i),
        .bp_is_branch_i       (bp_is_branch),
        .bp_taken_i           (bp_taken),
        .bp_target_i          (bp_target),
        .pc_o                 (pc),
        .req_valid_o          (req_valid_o),
        .req_vaddr_o          (req_vaddr_o),
        .req_inval_icache_o   (req_inval_icache_o),
        .req_inval_buffer_o   (req_inval_buffer_o),
        .req_inval_fetch_o    (req_inval_fetch_o),
        .fetch_valid_o        (fetch_valid_o),
        .fetch_pc_o           (fetch_pc_o),
        .fetch_ex_valid_o     (fetch_ex_valid_o),
        .fetch_ex_cause_o     (fetch_ex_cause_o),
        .fetch_ex_origin_o    (fetch_ex_origin_o),
        .fetch_bp_is_branch_o (fetch_bp_is_branch_o),
        .fetch_bp_decision_o  (fetch_bp_decision_o),
        .fetch_bp_addr_o      (fetch_bp_addr_o)
    );

    bp_update_router i_router (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .exe_valid_i  (exe_valid_i),
        .exe_pc_i     (exe_pc_i),
        .exe_target_i (exe_target_i),
        .exe_taken_i  (exe_taken_i),
        .wr_en_o      (wr_en),
        .wr_index_o   (wr_index),
        .wr_tag_o     (wr_tag),
        .wr_target_o  (wr_target),
        .wr_taken_o   (wr_taken)
    );

    // bank b owns slots b*BP_ENTRIES and up in the flat entry vector
    for (genvar b = 0; b < `BP_BANKS; b++) begin : g_bank
        bp_bank i_bank (
            .clk_i       (clk_i),
            .rstn_i      (rstn_i),
            .wr_en_i     (wr_en[b]),
            .wr_index_i  (wr_index),
            .wr_tag_i    (wr_tag),
            .wr_target_i (wr_target),
            .wr_taken_i  (wr_taken),
            .entries_o   (bank_entries[b*`BP_ENTRIES +: `BP_ENTRIES])
        );
    end

    bp_lookup_select i_lookup (
        .pc_i           (pc),
        .bank_entries_i (bank_entries),
        .is_branch_o    (bp_is_branch),
        .taken_o        (bp_taken),
        .target_o       (bp_target)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_frontend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end testbench
// replays per-cycle vectors from a data file and checks the outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_fetch_frontend
    import riscv_pkg::*;
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    NUM_FIELDS   = 24;
    localparam string TEST_FILE    = "testbench/fetch_tests.dat";

    logic         clk;
    logic         rstn;
    addr_t        reset_addr;
    logic         stall;
    logic         stall_debug;
    next_pc_sel_t next_pc_sel;
    pc_t          pc_jump;
    logic         inval_icache;
    logic         inval_buffer;
    logic         retry_fetch;
    logic         en_translation;
    logic         exe_valid;
    pc_t          exe_pc;
    pc_t          exe_target;
    logic         exe_taken;

    logic         req_valid;
    addr_t        req_vaddr;
    logic         req_inval_icache;
    logic         req_inval_buffer;
    logic         req_inval_fetch;
    logic         fetch_valid;
    pc_t          fetch_pc;
    logic         ex_valid;
    exc_cause_t   ex_cause;
    pc_t          ex_origin;
    logic         bp_is_branch;
    bp_decision_t bp_decision;
    pc_t          bp_addr;

    string       vec_lines[$];
    logic [63:0] fields [NUM_FIELDS];
    bit          loaded;
    int          vec_idx;
    int          checks;
    int          value_errors;
    int          other_errors;

    fetch_frontend i_dut (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .reset_addr_i         (reset_addr),
        .stall_i              (stall),
        .stall_debug_i        (stall_debug),
        .next_pc_sel_i        (next_pc_sel),
        .pc_jump_i            (pc_jump),
        .invalidate_icache_i  (inval_icache),
        .invalidate_buffer_i  (inval_buffer),
        .retry_fetch_i        (retry_fetch),
        .en_translation_i     (en_translation),
        .exe_valid_i          (exe_valid),
        .exe_pc_i             (exe_pc),
        .exe_target_i         (exe_target),
        .exe_taken_i          (exe_taken),
        .req_valid_o          (req_valid),
        .req_vaddr_o          (req_vaddr),
        .req_inval_icache_o   (req_inval_icache),
        .req_inval_buffer_o   (req_inval_buffer),
        .req_inval_fetch_o    (req_inval_fetch),
        .fetch_valid_o        (fetch_valid),
        .fetch_pc_o           (fetch_pc),
        .fetch_ex_valid_o     (ex_valid),
        .fetch_ex_cause_o     (ex_cause),
        .fetch_ex_origin_o    (ex_origin),
        .fetch_bp_is_branch_o (bp_is_branch),
        .fetch_bp_decision_o  (bp_decision),
        .fetch_bp_addr_o      (bp_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: vector %0d %s is %b, expected %b", $time, vec_idx, what, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: vector %0d %s is %h, expected %h", $time, vec_idx, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: vector %0d %s is %h, expected %h", $time, vec_idx, what, got, exp);
        end
    endtask

    task automatic check_cause(input exc_cause_t got, input exc_cause_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: vector %0d ex_cause is %0d, expected %0d", $time, vec_idx, got, exp);
        end
    endtask

    task automatic check_decision(input bp_decision_t got, input bp_decision_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: vector %0d bp_decision is %0d, expected %0d",
                     $time, vec_idx, got, exp);
        end
    endtask

    function automatic bit is_space(input byte c);
        return (c == 8'h20) || (c == 8'h09) || (c == 8'h0a) || (c == 8'h0d);
    endfunction

    task automatic load_vectors;
        int    fd;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s for reading", TEST_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment and blank lines carry no vector
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    vec_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // split one line into hex fields
    task automatic parse_vector(input string line, output int count);
        int    start;
        int    tokens;
        string token;
        count  = 0;
        tokens = 0;
        start  = -1;
        for (int k = 0; k <= line.len(); k++) begin
            if (k == line.len() || is_space(line.getc(k))) begin
                if (start >= 0) begin
                    token = line.substr(start, k - 1);
                    tokens++;
                    if (count < NUM_FIELDS) begin
                        if ($sscanf(token, "%h", fields[5'(count)]) == 1) begin
                            count++;
                        end
                    end
                    start = -1;
                end
            end else if (start < 0) begin
                start = k;
            end
        end
        // unreadable or surplus tokens spoil the vector
        if (tokens != count) begin
            count = -1;
        end
    endtask

    task automatic apply_inputs;
        next_pc_sel    = next_pc_sel_t'(fields[0][1:0]);
        stall          = fields[1][0];
        stall_debug    = fields[2][0];
        inval_icache   = fields[3][0];
        inval_buffer   = fields[4][0];
        retry_fetch    = fields[5][0];
        en_translation = fields[6][0];
        pc_jump        = fields[7];
        exe_valid      = fields[8][0];
        exe_taken      = fields[9][0];
        exe_pc         = fields[10];
        exe_target     = fields[11];
    endtask

    task automatic check_vector;
        check_bit("req_valid", req_valid, fields[12][0]);
        check_bit("fetch_valid", fetch_valid, fields[13][0]);
        check_addr("req_vaddr", req_vaddr, fields[14][39:0]);
        check_pc("fetch_pc", fetch_pc, fields[15]);
        check_bit("ex_valid", ex_valid, fields[16][0]);
        // cause and origin only mean something with an exception
        if (fields[16][0]) begin
            check_cause(ex_cause, exc_cause_t'(fields[17][3:0]));
            check_pc("ex_origin", ex_origin, fields[15]);
        end
        check_bit("bp_is_branch", bp_is_branch, fields[18][0]);
        check_decision(bp_decision, bp_decision_t'(fields[19][0]));
        // target of a missing entry is stale
        if (fields[18][0]) begin
            check_pc("bp_addr", bp_addr, fields[20]);
        end
        check_bit("req_inval_icache", req_inval_icache, fields[21][0]);
        check_bit("req_inval_buffer", req_inval_buffer, fields[22][0]);
        check_bit("req_inval_fetch", req_inval_fetch, fields[23][0]);
    endtask

    initial begin : run_tests
        int count;
        clk            = 1'b0;
        rstn           = 1'b0;
        reset_addr     = 40'h00_8000_0000;
        stall          = 1'b0;
        stall_debug    = 1'b0;
        next_pc_sel    = KEEP_PC;
        pc_jump        = '0;
        inval_icache   = 1'b0;
        inval_buffer   = 1'b0;
        retry_fetch    = 1'b0;
        en_translation = 1'b0;
        exe_valid      = 1'b0;
        exe_pc         = '0;
        exe_target     = '0;
        exe_taken      = 1'b0;
        load_vectors();
        loaded = 1'b1;
        if (vec_lines.size() == 0) begin
            $display("no test vectors were read from %s", TEST_FILE);
            other_errors++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rstn = 1'b1;
            foreach (vec_lines[i]) begin
                vec_idx = i;
                parse_vector(vec_lines[i], count);
                if (count != NUM_FIELDS) begin
                    $display("vector %0d is malformed, %0d fields read", i, count);
                    other_errors++;
                end else begin
                    apply_inputs();
                end
                // sample just before the next rising edge
                #(CLK_PERIOD - DRIVE_DELAY - 1);
                if (count == NUM_FIELDS) begin
                    check_vector();
                end
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        $display("checks run %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // one clock per vector plus slack for reset
    initial begin : watchdog
        wait (loaded);
        #(vec_lines.size() * CLK_PERIOD + 200);
        $display("timeout, the vectors did not complete in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/fetch_tests.dat ====
# in:  sel stall stall_dbg inv_icache inv_buffer retry translation jump exe_valid exe_taken exe_pc exe_target
# out: req_valid fetch_valid vaddr fetch_pc ex_valid cause is_branch decision bp_addr inv_icache inv_buffer inv_fetch
# all fields hex, one line per clock cycle
1 0 0 0 0 0 0 0 0 0 0 0  1 1 80000000 80000000 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0  1 1 80000004 80000004 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  1 1 80000008 80000008 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0  1 1 80000008 80000008 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80001000 0 0 0 0  1 1 8000000c 8000000c 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0 0 0  0 0 80001000 80001000 0 0 0 0 0 0 0 0
0 0 1 0 0 0 0 0 0 0 0 0  0 0 80001000 80001000 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 80002000 0 0 0 0  1 1 80001000 80001000 0 0 0 0 0 0 0 0
1 0 0 0 0 1 0 0 0 0 0 0  1 1 80002000 80002000 0 0 0 0 0 0 1 1
1 0 0 1 0 0 0 0 0 0 0 0  1 1 80002004 80002004 0 0 0 0 0 1 0 0
1 0 0 0 1 0 0 0 0 0 0 0  1 1 80002008 80002008 0 0 0 0 0 0 1 0
2 0 0 0 0 0 0 80002002 0 0 0 0  1 1 8000200c 8000200c 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80002001 0 0 0 0  0 1 80002002 80002002 1 0 0 0 0 0 0 0
2 0 0 0 0 0 0 800000000000 0 0 0 0  0 1 80002001 80002001 1 0 0 0 0 0 0 0
2 0 0 0 0 0 1 200000 0 0 0 0  0 1 0 800000000000 1 1 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 1 200000 200000 1 1 0 0 0 0 0 0
2 0 0 0 0 0 1 200002 0 0 0 0  1 1 200000 200000 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80000100 0 0 0 0  0 1 200002 200002 1 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 1 1 80000100 80000400  1 1 80000100 80000100 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80000100 0 0 0 0  1 1 80000104 80000104 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 1 0 80000100 80000400  1 1 80000100 80000100 0 0 1 1 80000400 0 0 0
1 0 0 0 0 0 0 0 1 0 80000100 80000400  1 1 80000400 80000400 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80000100 0 0 0 0  1 1 80000404 80000404 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0  1 1 80000100 80000100 0 0 1 0 80000400 0 0 0
2 0 0 0 0 0 0 80000100 1 1 80000180 80000800  1 1 80000104 80000104 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 1 1 80000104 80000900  1 1 80000100 80000100 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0  1 1 80000104 80000104 0 0 1 1 80000900 0 0 0
2 0 0 0 0 0 0 80000180 0 0 0 0  1 1 80000900 80000900 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 80000104 0 0 0 0  1 1 80000180 80000180 0 0 1 1 80000800 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  1 1 80000104 80000104 0 0 1 1 80000900 0 0 0
0 0 0 0 0 1 0 0 0 0 0 0  1 1 80000104 80000104 0 0 1 1 80000900 0 1 1

// ==== sim.f ====
+incdir+source
source/riscv_pkg.sv
source/fetch_pkg.sv
source/bp_update_router.sv
source/bp_bank.sv
source/bp_lookup_select.sv
source/fetch_pc_stage.sv
source/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fetch_frontend

verilator --binary --timing --assert -f sim.f --top-module "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
